// ==== accel_pkg.sv ====
package accel_pkg;

  localparam int ACCEL_COUNT     = 4;
  localparam int ACCEL_ID_WIDTH  = 2;
  localparam int IO_ADDR_WIDTH   = 9;
  localparam int IO_DATA_WIDTH   = 32;
  localparam int IO_STRB_WIDTH   = IO_DATA_WIDTH / 8;
  localparam int MEM_ADDR_WIDTH  = 8;
  localparam int BYTE_ADDR_WIDTH = MEM_ADDR_WIDTH + 2;
  localparam int LEN_WIDTH       = 10;
  localparam int HASH_MAX_BITS   = 128;
  localparam int HASH_KEY_BITS   = HASH_MAX_BITS + 32;
  localparam int HASH_CNT_WIDTH  = $clog2(HASH_MAX_BITS + 1);

  // leading 160 bits of the usual RSS key, msb is key bit 0
  localparam logic [HASH_KEY_BITS-1:0] HASH_KEY =
    160'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcb;

  localparam logic [IO_ADDR_WIDTH-1:0] REG_CTRL     = 9'h000; // per-accelerator block
  localparam logic [IO_ADDR_WIDTH-1:0] REG_LEN      = 9'h004;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_ADDR     = 9'h008;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_PATTERN  = 9'h00C;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_STATUS   = 9'h080;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_HASH_CLR = 9'h100;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_HASH_B1  = 9'h104;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_HASH_B2  = 9'h108;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_HASH_B4  = 9'h10C;

  typedef struct packed {
    logic                     en;
    logic                     wen;
    logic [IO_STRB_WIDTH-1:0] strb;
    logic [IO_ADDR_WIDTH-1:0] addr;
    logic [IO_DATA_WIDTH-1:0] wr_data;
  } io_req_t;

  typedef struct packed {
    logic [IO_DATA_WIDTH-1:0] rd_data;
    logic                     rd_valid;
  } io_rsp_t;

  typedef struct packed {
    logic [ACCEL_ID_WIDTH-1:0]  accel;
    logic [BYTE_ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]       len;
  } dma_desc_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  typedef struct packed {
    logic [31:0] data;
    logic [2:0]  nbytes; // 1, 2 or 4
  } hash_in_t;

  typedef struct packed {
    logic                      en;
    logic [MEM_ADDR_WIDTH-1:0] addr;
    logic [31:0]               data;
  } mem_wr_t;

endpackage

// ==== pattern_matcher.sv ====
module pattern_matcher (
  input  logic        clk,
  input  logic        rst,
  input  logic        init,
  input  logic [31:0] pattern,
  input  logic [7:0]  in_byte,
  input  logic        in_valid,
  output logic        match
);

  logic [31:0] pat_q;
  logic [23:0] hist_q; // three previous bytes, oldest in bits 7:0
  logic [1:0]  fill_q;

  // the incoming byte closes the window, so the pulse comes with it
  assign match = in_valid && fill_q == 2'd3 && {in_byte, hist_q} == pat_q;

  always_ff @(posedge clk) begin
    if (rst || init) begin
      fill_q <= 2'd0;
    end else if (in_valid && fill_q != 2'd3) begin
      fill_q <= fill_q + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (init) begin
      pat_q  <= pattern;
      hist_q <= '0;
    end else if (in_valid) begin
      hist_q <= {in_byte, hist_q[23:8]};
    end
  end

endmodule

// ==== pkt_mem.sv ====
module pkt_mem import accel_pkg::*; (
  input  logic                      clk,
  input  mem_wr_t                   load,
  input  logic                      rd_en,
  input  logic [MEM_ADDR_WIDTH-1:0] rd_addr,
  output logic [31:0]               rd_data
);

  logic [31:0] mem [2**MEM_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // read data holds until the next enabled read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== pkt_rd_dma.sv ====
module pkt_rd_dma import accel_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_desc_t                 desc,
  input  logic                      desc_valid,
  input  logic [ACCEL_COUNT-1:0]    stop,
  output logic [ACCEL_COUNT-1:0]    busy,
  output logic                      mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr,
  input  logic [31:0]               mem_rd_data,
  output byte_beat_t                beat,
  output logic [ACCEL_COUNT-1:0]    beat_valid
);

  logic                       active_q;
  logic [ACCEL_ID_WIDTH-1:0]  accel_q;
  logic [BYTE_ADDR_WIDTH-1:0] ptr_q;
  logic [LEN_WIDTH-1:0]       rem_q;
  logic                       s1_valid_q;
  logic [1:0]                 s1_lane_q;
  logic                       s1_last_q;
  logic                       busy_any;
  logic                       stop_hit;
  logic                       start;
  logic                       issue;
  logic                       issue_last;
  logic [BYTE_ADDR_WIDTH-1:0] issue_addr;

  assign busy_any = active_q || s1_valid_q || (|beat_valid);
  assign busy     = busy_any ? ACCEL_COUNT'(1) << accel_q : '0;
  assign stop_hit = busy_any && stop[accel_q];
  assign start    = desc_valid && !busy_any;

  // the byte handled this cycle comes straight from the descriptor on a start
  always_comb begin
    if (start) begin
      issue      = desc.len != '0;
      issue_addr = desc.addr;
      issue_last = desc.len == LEN_WIDTH'(1);
    end else begin
      issue      = active_q && rem_q != '0 && !stop_hit;
      issue_addr = ptr_q;
      issue_last = rem_q == LEN_WIDTH'(1);
    end
  end

  assign mem_rd_en   = issue && (start || issue_addr[1:0] == 2'b00); // new word entered
  assign mem_rd_addr = issue_addr[BYTE_ADDR_WIDTH-1:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q   <= 1'b0;
      s1_valid_q <= 1'b0;
      beat_valid <= '0;
    end else begin
      if (stop_hit) begin
        active_q   <= 1'b0;
        s1_valid_q <= 1'b0;
        beat_valid <= '0;
      end else begin
        if (start) begin
          active_q <= 1'b1;
        end else if (active_q && rem_q == '0) begin
          active_q <= 1'b0; // a zero length leaves busy up for this one cycle
        end
        s1_valid_q <= issue;
        beat_valid <= s1_valid_q ? ACCEL_COUNT'(1) << accel_q : '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      accel_q <= desc.accel;
      ptr_q   <= desc.addr + 1'b1;
      rem_q   <= (desc.len == '0) ? '0 : desc.len - 1'b1;
    end else if (issue) begin
      ptr_q <= ptr_q + 1'b1;
      rem_q <= rem_q - 1'b1;
    end
    s1_lane_q <= issue_addr[1:0];
    s1_last_q <= issue_last;
    // the memory output still holds the word of this lane
    beat.data <= mem_rd_data[s1_lane_q*8 +: 8]; // little-endian lanes
    beat.last <= s1_last_q;
  end

endmodule

// ==== toeplitz_hash.sv ====
module toeplitz_hash import accel_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  hash_in_t    data,
  input  logic        valid,
  input  logic        clear,
  output logic [31:0] hash_out
);

  logic [HASH_CNT_WIDTH-1:0] bit_cnt_q;
  logic [HASH_CNT_WIDTH:0]   cnt_sum;
  logic [HASH_CNT_WIDTH-1:0] cnt_next;
  logic [5:0]                nbits;
  logic [HASH_CNT_WIDTH:0]   pos;
  logic [HASH_KEY_BITS-1:0]  key_shift;
  logic [31:0]               hash_next;

  always_comb begin
    nbits     = {data.nbytes, 3'b000};
    hash_next = hash_out;
    pos       = '0;
    key_shift = '0;
    // byte 0 first, msb first inside each byte
    for (int j = 0; j < 32; j++) begin
      pos       = (HASH_CNT_WIDTH + 1)'(bit_cnt_q) + (HASH_CNT_WIDTH + 1)'(j);
      key_shift = HASH_KEY << pos;
      if (j < nbits && pos < HASH_MAX_BITS && data.data[(j / 8) * 8 + 7 - (j % 8)]) begin
        hash_next = hash_next ^ key_shift[HASH_KEY_BITS-1 -: 32];
      end
    end
    cnt_sum = (HASH_CNT_WIDTH + 1)'(bit_cnt_q) + (HASH_CNT_WIDTH + 1)'(nbits);
    if (cnt_sum >= HASH_MAX_BITS) begin
      cnt_next = HASH_CNT_WIDTH'(HASH_MAX_BITS);
    end else begin
      cnt_next = cnt_sum[HASH_CNT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      hash_out  <= '0;
      bit_cnt_q <= '0;
    end else if (valid) begin
      hash_out  <= hash_next;
      bit_cnt_q <= cnt_next;
    end
  end

endmodule

// ==== accel_regs.sv ====
module accel_regs import accel_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  io_req_t                       io_req,
  output io_rsp_t                       io_rsp,
  output dma_desc_t                     dma_desc,
  output logic                          desc_valid,
  output logic [ACCEL_COUNT-1:0]        stop,
  output logic [ACCEL_COUNT-1:0]        init,
  output logic [ACCEL_COUNT-1:0][31:0]  pattern,
  input  logic [ACCEL_COUNT-1:0]        busy,
  input  logic [ACCEL_COUNT-1:0]        beat_valid,
  input  logic                          beat_last,
  input  logic [ACCEL_COUNT-1:0]        match,
  output hash_in_t                      hash_in,
  output logic                          hash_valid,
  output logic                          hash_clear,
  input  logic [31:0]                   hash_out
);

  logic [LEN_WIDTH-1:0]       len_q;
  logic [BYTE_ADDR_WIDTH-1:0] addr_q;
  logic [ACCEL_ID_WIDTH-1:0]  accel_q;
  logic [ACCEL_COUNT-1:0]     done_q;
  logic [ACCEL_COUNT-1:0]     match_q;
  logic [31:0]                hash_data_q;
  logic [2:0]                 hash_nbytes_q;
  logic                       hash_stall_q;
  logic [IO_DATA_WIDTH-1:0]   rd_data_q;
  logic                       rd_valid_q;
  logic [IO_DATA_WIDTH-1:0]   rd_mux;
  logic [ACCEL_ID_WIDTH-1:0]  sel;
  logic [3:0]                 off;
  logic                       wr;
  logic                       rd;
  logic                       acc_blk;
  logic                       hash_blk;
  logic                       ctrl_wr;
  logic                       start_req;
  logic                       hash_wr;

  assign sel       = io_req.addr[5:4];
  assign off       = {io_req.addr[3:2], 2'b00};
  assign wr        = io_req.en && io_req.wen;
  assign rd        = io_req.en && !io_req.wen;
  assign acc_blk   = io_req.addr[8:7] == 2'b00;
  assign hash_blk  = io_req.addr[8];
  assign ctrl_wr   = wr && acc_blk && off == REG_CTRL[3:0] && io_req.strb[0];
  assign start_req = ctrl_wr && io_req.wr_data[0] && !(|busy); // dropped while the DMA runs
  assign hash_wr   = wr && (io_req.addr == REG_HASH_B1 || io_req.addr == REG_HASH_B2 ||
                            io_req.addr == REG_HASH_B4);

  assign dma_desc = '{accel: accel_q, addr: addr_q, len: len_q};
  assign hash_in  = '{data: hash_data_q, nbytes: hash_nbytes_q};
  assign io_rsp   = '{rd_data: rd_data_q, rd_valid: rd_valid_q};

  always_comb begin
    rd_mux = '0;
    if (hash_blk) begin
      rd_mux = hash_out;
    end else if (io_req.addr == REG_STATUS) begin
      rd_mux[2*ACCEL_COUNT-1:0] = {match_q, done_q};
    end else if (acc_blk) begin
      case (off)
        REG_CTRL[3:0]: begin
          rd_mux[1] = busy[sel];
          rd_mux[8] = done_q[sel];
          rd_mux[9] = match_q[sel];
        end
        REG_LEN[3:0]:     rd_mux[LEN_WIDTH-1:0] = len_q;
        REG_ADDR[3:0]:    rd_mux[BYTE_ADDR_WIDTH-1:0] = addr_q;
        REG_PATTERN[3:0]: rd_mux = pattern[sel];
        default:          rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid   <= 1'b0;
      stop         <= '0;
      init         <= '0;
      hash_valid   <= 1'b0;
      hash_clear   <= 1'b0;
      hash_stall_q <= 1'b0;
      rd_valid_q   <= 1'b0;
      done_q       <= '0;
      match_q      <= '0;
    end else begin
      desc_valid <= start_req;
      stop       <= '0;
      init       <= '0;
      if (start_req) init[sel] <= 1'b1;
      if (ctrl_wr) stop[sel] <= io_req.wr_data[4];
      hash_valid <= hash_wr;
      hash_clear <= wr && io_req.addr == REG_HASH_CLR;
      // a hash read right behind a data write waits for the updated hash
      hash_stall_q <= rd && hash_blk && hash_valid;
      rd_valid_q   <= (rd && !(hash_blk && hash_valid)) || hash_stall_q;
      done_q  <= (done_q | (beat_valid & {ACCEL_COUNT{beat_last}}) | stop) & ~init;
      match_q <= (match_q | match) & ~init;
    end
  end

  always_ff @(posedge clk) begin
    if (start_req) accel_q <= sel;
    if (wr && acc_blk && off == REG_LEN[3:0]) len_q <= io_req.wr_data[LEN_WIDTH-1:0];
    if (wr && acc_blk && off == REG_ADDR[3:0]) addr_q <= io_req.wr_data[BYTE_ADDR_WIDTH-1:0];
    if (wr && acc_blk && off == REG_PATTERN[3:0]) pattern[sel] <= io_req.wr_data;
    if (hash_wr) begin
      hash_data_q <= io_req.wr_data;
      case (io_req.addr)
        REG_HASH_B1: hash_nbytes_q <= 3'd1;
        REG_HASH_B2: hash_nbytes_q <= 3'd2;
        default:     hash_nbytes_q <= 3'd4;
      endcase
    end
    if (hash_stall_q) begin
      rd_data_q <= hash_out;
    end else if (rd) begin
      rd_data_q <= rd_mux;
    end
  end

endmodule

// ==== accel_top.sv ====
module accel_top import accel_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  io_req_t io_req,
  output io_rsp_t io_rsp,
  input  mem_wr_t mem_load
);

  dma_desc_t                    dma_desc;
  logic                         desc_valid;
  logic [ACCEL_COUNT-1:0]       stop;
  logic [ACCEL_COUNT-1:0]       init;
  logic [ACCEL_COUNT-1:0]       busy;
  logic [ACCEL_COUNT-1:0]       beat_valid;
  logic [ACCEL_COUNT-1:0]       match;
  logic [ACCEL_COUNT-1:0][31:0] pattern;
  byte_beat_t                   beat;
  hash_in_t                     hash_in;
  logic                         hash_valid;
  logic                         hash_clear;
  logic [31:0]                  hash_out;
  logic                         mem_rd_en;
  logic [MEM_ADDR_WIDTH-1:0]    mem_rd_addr;
  logic [31:0]                  mem_rd_data;

  accel_regs regs (
    .clk(clk), .rst(rst), .io_req(io_req), .io_rsp(io_rsp),
    .dma_desc(dma_desc), .desc_valid(desc_valid), .stop(stop), .init(init),
    .pattern(pattern), .busy(busy), .beat_valid(beat_valid), .beat_last(beat.last),
    .match(match), .hash_in(hash_in), .hash_valid(hash_valid), .hash_clear(hash_clear),
    .hash_out(hash_out)
  );

  pkt_mem mem (
    .clk(clk), .load(mem_load), .rd_en(mem_rd_en), .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data)
  );

  pkt_rd_dma dma (
    .clk(clk), .rst(rst), .desc(dma_desc), .desc_valid(desc_valid), .stop(stop),
    .busy(busy), .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data), .beat(beat), .beat_valid(beat_valid)
  );

  for (genvar i = 0; i < ACCEL_COUNT; i++) begin : g_matcher
    pattern_matcher matcher (
      .clk(clk), .rst(rst), .init(init[i]), .pattern(pattern[i]),
      .in_byte(beat.data), .in_valid(beat_valid[i]), .match(match[i])
    );
  end

  toeplitz_hash hash (
    .clk(clk), .rst(rst), .data(hash_in), .valid(hash_valid), .clear(hash_clear),
    .hash_out(hash_out)
  );

endmodule

// ==== accel_checker.sv ====
module accel_checker import accel_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  io_req_t      io_req,
  input  io_rsp_t      io_rsp,
  input  logic         chk,
  input  logic [31:0]  exp_data,
  input  logic [127:0] exp_name,
  output int           checks,
  output int           value_errors,
  output int           other_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic         pending;
  logic         pend_chk;
  logic [31:0]  pend_exp;
  logic [127:0] pend_name;
  int           wait_cnt;

  always @(posedge clk) begin
    if (rst) begin
      pending      <= 1'b0;
      wait_cnt     <= 0;
      checks       <= 0;
      value_errors <= 0;
      other_errors <= 0;
    end else begin
      if (io_rsp.rd_valid) begin
        if (!pending) begin
          $display("read response seen with no read request outstanding");
          other_errors <= other_errors + 1;
        end else if (pend_chk) begin
          checks <= checks + 1;
          if (io_rsp.rd_data !== pend_exp) begin
            $display("error %0s: expected %h, actual %h", pend_name, pend_exp, io_rsp.rd_data);
            value_errors <= value_errors + 1;
          end
        end
        pending <= 1'b0;
      end else if (pending) begin
        // a stalled hash read answers on the second cycle, so three is plenty
        if (wait_cnt == 2) begin
          $display("no read response within 3 cycles of the request for %0s", pend_name);
          other_errors <= other_errors + 1;
          pending      <= 1'b0;
        end
        wait_cnt <= wait_cnt + 1;
      end
      if (io_req.en && !io_req.wen) begin
        pending   <= 1'b1;
        pend_chk  <= chk;
        pend_exp  <= exp_data;
        pend_name <= exp_name;
        wait_cnt  <= 0;
      end
    end
  end

endmodule

// ==== tb_accel.sv ====
module tb_accel import accel_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RSP_LIMIT  = 8;  // cycles to wait for rd_valid
  localparam int POLL_LIMIT = 64; // reads before a poll gives up

  logic         clk;
  logic         rst;
  io_req_t      io_req;
  io_rsp_t      io_rsp;
  mem_wr_t      mem_load;
  logic         chk;
  logic [31:0]  exp_data;
  logic [127:0] exp_name;
  int           checks;
  int           value_errors;
  int           other_errors;
  int           run_errors;
  logic         timed_out;

  accel_top dut (
    .clk(clk), .rst(rst), .io_req(io_req), .io_rsp(io_rsp), .mem_load(mem_load)
  );

  accel_checker monitor (
    .clk(clk), .rst(rst), .io_req(io_req), .io_rsp(io_rsp), .chk(chk),
    .exp_data(exp_data), .exp_name(exp_name), .checks(checks),
    .value_errors(value_errors), .other_errors(other_errors)
  );

  always #5 clk = ~clk;

  task automatic idle_bus();
    io_req = '{en: 1'b0, wen: 1'b0, strb: '0, addr: '0, wr_data: '0};
    chk    = 1'b0;
  endtask

  task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
    io_req = '{en: 1'b1, wen: 1'b1, strb: 4'hf, addr: addr, wr_data: data};
    @(negedge clk);
    idle_bus();
  endtask

  task automatic mem_write(input logic [7:0] addr, input logic [31:0] data);
    mem_load = '{en: 1'b1, addr: addr, data: data};
    @(negedge clk);
    mem_load.en = 1'b0;
  endtask

  // the checker only compares the response when check is set
  task automatic bus_read(input logic [8:0] addr, input logic check, input logic [31:0] exp_val,
                          input logic [127:0] name, output logic [31:0] data);
    int n;
    io_req   = '{en: 1'b1, wen: 1'b0, strb: '0, addr: addr, wr_data: '0};
    chk      = check;
    exp_data = exp_val;
    exp_name = name;
    @(negedge clk);
    idle_bus();
    n = 0;
    while (!io_rsp.rd_valid && n < RSP_LIMIT) begin
      @(negedge clk);
      n++;
    end
    data = io_rsp.rd_data;
    if (!io_rsp.rd_valid) begin
      $display("timeout: no read response for address %h (%0s)", addr, name);
      run_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic bus_poll(input logic [8:0] addr, input logic [31:0] mask,
                          input logic [31:0] exp_val, input logic [127:0] name);
    logic [31:0] data;
    logic        hit;
    int          tries;
    hit   = 1'b0;
    tries = 0;
    while (!hit && !timed_out && tries < POLL_LIMIT) begin
      bus_read(addr, 1'b0, '0, name, data);
      hit = (data & mask) === (exp_val & mask);
      tries++;
    end
    if (!hit && !timed_out) begin
      $display("timeout: poll %0s never saw the expected bits at address %h", name, addr);
      run_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic bad_line(input string line);
    $display("malformed line in the vectors file: %s", line);
    run_errors++;
  endtask

  task automatic run_command(input string line);
    logic [63:0]  cmd;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  c;
    logic [31:0]  data;
    logic [127:0] name;
    int           code;
    cmd  = '0;
    name = '0;
    code = $sscanf(line, "%s", cmd);
    case (cmd)
      "L": begin
        code = $sscanf(line, "%s %h %h", cmd, a, b);
        if (code == 3) mem_write(a[7:0], b);
        else bad_line(line);
      end
      "W": begin
        code = $sscanf(line, "%s %h %h", cmd, a, b);
        if (code == 3) bus_write(a[8:0], b);
        else bad_line(line);
      end
      "R": begin
        code = $sscanf(line, "%s %h %h %s", cmd, a, b, name);
        if (code == 4) bus_read(a[8:0], 1'b1, b, name, data);
        else bad_line(line);
      end
      "P": begin
        code = $sscanf(line, "%s %h %h %h %s", cmd, a, b, c, name);
        if (code == 5) bus_poll(a[8:0], b, c, name);
        else bad_line(line);
      end
      default: bad_line(line);
    endcase
  endtask

  initial begin
    string       line;
    logic [63:0] first;
    int          fd;
    int          code;
    clk        = 1'b0;
    rst        = 1'b1;
    mem_load   = '0;
    exp_data   = '0;
    exp_name   = '0;
    run_errors = 0;
    timed_out  = 1'b0;
    idle_bus();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk); // quiet bus so a stray rd_valid shows up
    fd = $fopen("accel_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open accel_vectors.txt");
      run_errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line  = "";
        first = '0;
        code  = $fgets(line, fd);
        code  = $sscanf(line, "%s", first);
        if (code == 1 && first != "#") run_command(line);
      end
      $fclose(fd);
    end
    repeat (5) @(negedge clk);
    $display("reads checked %0d, wrong values %0d, response errors %0d, run errors %0d",
             checks, value_errors, other_errors, run_errors);
    if (checks > 0 && value_errors == 0 && other_errors == 0 && run_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== accel_vectors.txt ====
# L word_addr data | W byte_addr data | R byte_addr expected name
# P byte_addr mask expected name, repeated until the masked bits match
R 080 00000000 status_reset
R 000 00000000 ctrl0_reset
R 010 00000000 ctrl1_reset
R 020 00000000 ctrl2_reset
R 030 00000000 ctrl3_reset
L 00 33221100
L 01 bafeca44
L 02 bbaa99be
L 03 77665544
W 004 0000000a
W 008 00000003
W 00c 5a5aa5a5
W 01c bebafeca
W 02c 11223344
W 03c ffffffff
R 004 0000000a len_readback
R 008 00000003 addr_readback
R 00c 5a5aa5a5 pattern0
R 01c bebafeca pattern1
R 02c 11223344 pattern2
R 03c ffffffff pattern3
W 010 00000001
P 010 00000100 00000100 acc1_done
R 080 00000022 status_acc1
R 010 00000300 ctrl1_match
W 020 00000001
P 020 00000100 00000100 acc2_done
R 080 00000026 status_acc2
W 008 00000000
W 004 000003ff
W 030 00000001
P 030 00000002 00000002 acc3_busy
W 030 00000010
P 030 00000102 00000100 acc3_stopped
R 030 00000100 ctrl3_stopped
R 080 0000002e status_stop
W 100 00000000
R 100 00000000 hash_clear
W 10c 08000880
R 100 6a624463 hash_b4
W 108 ffff0808
R 100 8f3e8c51 hash_b2
W 104 abcdef88
R 10c 6dd8db44 hash_b1

// ==== vlog.f ====
accel_pkg.sv
pattern_matcher.sv
pkt_mem.sv
pkt_rd_dma.sv
toeplitz_hash.sv
accel_regs.sv
accel_top.sv
accel_checker.sv
tb_accel.sv

// ==== Bender.yml ====
package:
  name: accel

sources:
  - files:
      - accel_pkg.sv
      - pattern_matcher.sv
      - pkt_mem.sv
      - pkt_rd_dma.sv
      - toeplitz_hash.sv
      - accel_regs.sv
      - accel_top.sv
  - target: test
    files:
      - accel_checker.sv
      - tb_accel.sv
